//--- Bender.yml
package:
  name: blink

sources:
  - blink_pkg.sv
  - z80_clock_gen.sv
  - mem_map.sv
  - io_bus.sv
  - rtc_timer.sv
  - keyboard_scan.sv
  - int_ctrl.sv
  - blink_top.sv
  - target: test
    files:
      - tb_blink.sv

//--- blink_pkg.sv
`default_nettype none

package blink_pkg;

  // I/O port map, low address byte
  localparam logic [7:0] com_port  = 8'hB0;  // COM control, write
  localparam logic [7:0] int_port  = 8'hB1;  // INT mask, write
  localparam logic [7:0] sta_port  = 8'hB1;  // STA status, read
  localparam logic [7:0] kbd_port  = 8'hB2;  // Keyboard row read
  localparam logic [7:0] tack_port = 8'hB4;  // Timer acknowledge, write
  localparam logic [7:0] tsta_port = 8'hB5;  // Timer status, read
  localparam logic [7:0] tmk_port  = 8'hB5;  // Timer mask, write
  localparam logic [7:0] ack_port  = 8'hB6;  // Main int acknowledge

  // Segment registers on write, time counters on read
  localparam logic [7:0] sr0_port  = 8'hD0;
  localparam logic [7:0] sr1_port  = 8'hD1;
  localparam logic [7:0] sr2_port  = 8'hD2;
  localparam logic [7:0] sr3_port  = 8'hD3;
  localparam logic [7:0] tim0_port = 8'hD0;  // 5 ms ticks
  localparam logic [7:0] tim1_port = 8'hD1;  // Seconds
  localparam logic [7:0] tim2_port = 8'hD2;  // Minutes, low byte
  localparam logic [7:0] tim3_port = 8'hD3;  // Minutes, mid byte
  localparam logic [7:0] tim4_port = 8'hD4;  // Minutes, top bits

  localparam int seg_w  = 8;   // Bank number
  localparam int phys_w = 22;  // Physical bus
  localparam int tim0_w = 8;
  localparam int tim1_w = 6;
  localparam int timm_w = 21;
  localparam int tsta_w = 3;   // TICK, SEC, MIN

  localparam logic [tim0_w-1:0] tim0_max = 8'd199;  // 200 ticks per second
  localparam logic [tim1_w-1:0] tim1_max = 6'd59;

  // Reset values
  localparam logic [7:0] reg_rst = 8'h00;
  localparam logic       run_rst = 1'b1;  // Z80 clock running out of reset

  // One register write, valid while strobe is high
  typedef struct packed {
    logic       strobe;
    logic [7:0] port;
    logic [7:0] data;
    logic [7:0] addr_hi;  // Upper address byte, keyboard row select
  } io_wr_t;

  // RTC state visible to the CPU
  typedef struct packed {
    logic [tim0_w-1:0] tim0;
    logic [tim1_w-1:0] tim1;
    logic [timm_w-1:0] timm;
    logic [tsta_w-1:0] tsta;
  } rtc_time_t;

  // Z80 control levels, all active low
  typedef struct packed {
    logic mrq_n;
    logic crd_n;
    logic ior_n;
    logic cm1_n;
    logic hlt_n;
  } z80_ctl_t;

endpackage

`default_nettype wire

//--- blink_top.f
blink_pkg.sv
z80_clock_gen.sv
mem_map.sv
io_bus.sv
rtc_timer.sv
keyboard_scan.sv
int_ctrl.sv
blink_top.sv
tb_blink.sv

//--- blink_top.sv
`default_nettype none

module blink_top #(
  parameter int tick_div = 49152
) (
  input  logic        mck,
  input  logic        rst,
  input  logic [15:0] ca,
  input  logic [21:0] va,
  input  logic [7:0]  cdi,
  input  logic [63:0] kbmat,
  input  logic        flp,
  input  logic        mrq_n,
  input  logic        crd_n,
  input  logic        ior_n,
  input  logic        cm1_n,
  input  logic        hlt_n,
  output logic [21:0] ma,
  output logic [7:0]  z80_cdo,
  output logic [1:0]  clkcnt,
  output logic        pm1,
  output logic        ipce_n,
  output logic        irce_n,
  output logic        wrb_n,
  output logic        roe_n,
  output logic        intb_n,
  output logic        nmib_n
);
  import blink_pkg::*;

  z80_ctl_t  ctl;
  io_wr_t    io_wr;
  rtc_time_t rtc_time;
  logic [7:0] sta;
  logic [7:0] kbd;
  logic       zac;
  logic       restim;
  logic       rd_strobe;
  logic       rtc_int;
  logic       kbd_status;
  logic       int_active;
  logic       snooze_req;

  assign ctl = '{mrq_n: mrq_n, crd_n: crd_n, ior_n: ior_n, cm1_n: cm1_n, hlt_n: hlt_n};

  z80_clock_gen u_clk (
    .mck(mck), .rst(rst), .int_active(int_active), .hlt_n(ctl.hlt_n),
    .snooze_req(snooze_req), .zac(zac), .clkcnt(clkcnt), .pm1(pm1)
  );

  mem_map u_map (
    .mck(mck), .rst(rst), .ca(ca), .va(va), .io_wr(io_wr), .ctl(ctl), .zac(zac),
    .restim(restim), .ma(ma), .ipce_n(ipce_n), .irce_n(irce_n),
    .wrb_n(wrb_n), .roe_n(roe_n)
  );

  io_bus u_io (
    .mck(mck), .rst(rst), .ca(ca), .cdi(cdi), .ctl(ctl), .zac(zac),
    .rtc_time(rtc_time), .sta(sta), .kbd(kbd), .io_wr(io_wr),
    .rd_strobe(rd_strobe), .z80_cdo(z80_cdo)
  );

  rtc_timer #(.tick_div(tick_div)) u_rtc (
    .mck(mck), .rst(rst), .flp(flp), .restim(restim), .io_wr(io_wr),
    .rtc_time(rtc_time), .rtc_int(rtc_int)
  );

  // Row select rides on the upper address byte
  keyboard_scan u_kbd (
    .mck(mck), .rst(rst), .ca_high(io_wr.addr_hi), .kbmat(kbmat), .io_wr(io_wr),
    .kbd(kbd), .kbd_status(kbd_status)
  );

  int_ctrl u_int (
    .mck(mck), .rst(rst), .flp(flp), .ctl(ctl), .io_wr(io_wr),
    .rd_strobe(rd_strobe), .port(io_wr.port), .rtc_int(rtc_int),
    .kbd_status(kbd_status), .sta(sta), .int_active(int_active),
    .snooze_req(snooze_req), .intb_n(intb_n), .nmib_n(nmib_n)
  );

endmodule

`default_nettype wire

//--- int_ctrl.sv
`default_nettype none

module int_ctrl (
  input  logic                 mck,
  input  logic                 rst,
  input  logic                 flp,
  input  blink_pkg::z80_ctl_t  ctl,
  input  blink_pkg::io_wr_t    io_wr,
  input  logic                 rd_strobe,
  input  logic [7:0]           port,
  input  logic                 rtc_int,
  input  logic                 kbd_status,
  output logic [7:0]           sta,
  output logic                 int_active,
  output logic                 snooze_req,
  output logic                 intb_n,
  output logic                 nmib_n
);
  import blink_pkg::*;

  // INT register bit positions
  localparam int gint_b = 0;
  localparam int time_b = 1;
  localparam int key_b  = 2;
  localparam int flap_b = 5;

  logic [6:0] int_r;    // INT bits 6..0
  logic       kwait;    // INT bit 7
  logic       flap_f;   // Flap status
  logic       kbd_rd;   // KBD port read
  logic       int_req;
  logic       int_set;  // Registered request
  logic       intb;     // INT latch

  assign kbd_rd = rd_strobe && (port == kbd_port);

  always_ff @(posedge mck) begin
    if (rst) begin
      int_r  <= '0;
      kwait  <= 1'b0;
      flap_f <= 1'b0;
    end else begin
      if (io_wr.strobe && io_wr.port == int_port) begin
        int_r <= io_wr.data[6:0];
        if (io_wr.data[7]) begin
          kwait <= 1'b1;
        end
      end else if (kbd_rd) begin
        kwait <= 1'b0;  // One snooze per KWAIT write
      end
      if (flp) begin
        flap_f <= 1'b1;
      end else if (io_wr.strobe && io_wr.port == ack_port && io_wr.data[5]) begin
        flap_f <= 1'b0;
      end
    end
  end

  assign sta = {flp, 1'b0, flap_f, 2'b00, kbd_status, 1'b0, rtc_int};

  assign int_req = int_r[gint_b] && ((int_r[time_b] && rtc_int) ||
                                     (int_r[key_b]  && kbd_status) ||
                                     (int_r[flap_b] && flap_f));

  always_ff @(posedge mck) begin
    if (rst) begin
      int_set <= 1'b0;
      intb    <= 1'b0;
    end else begin
      int_set <= int_req;
      if (int_set) begin
        intb <= 1'b1;
      end else if (!ctl.ior_n && !ctl.cm1_n) begin
        intb <= 1'b0;  // Z80 interrupt acknowledge cycle
      end
    end
  end

  assign int_active = intb;
  assign intb_n     = ~intb;
  assign nmib_n     = ~flp;             // NMI while flap open
  assign snooze_req = kbd_rd && kwait;  // Stops pm1 until next INT

endmodule

`default_nettype wire

//--- io_bus.sv
`default_nettype none

module io_bus (
  input  logic                  mck,
  input  logic                  rst,
  input  logic [15:0]           ca,
  input  logic [7:0]            cdi,
  input  blink_pkg::z80_ctl_t   ctl,
  input  logic                  zac,
  input  blink_pkg::rtc_time_t  rtc_time,
  input  logic [7:0]            sta,
  input  logic [7:0]            kbd,
  output blink_pkg::io_wr_t     io_wr,
  output logic                  rd_strobe,
  output logic [7:0]            z80_cdo
);
  import blink_pkg::*;

  logic [7:0] rd_q;   // Port read-back register
  logic [7:0] cdi_q;  // CPU data latch

  // IORQ with WR, one cycle wide in zac
  assign io_wr = '{strobe:  zac && !ctl.ior_n && ctl.crd_n,
                   port:    ca[7:0],
                   data:    cdi,
                   addr_hi: ca[15:8]};

  assign rd_strobe = zac && !ctl.ior_n && !ctl.crd_n;

  always_ff @(posedge mck) begin
    if (rst) begin
      rd_q  <= reg_rst;
      cdi_q <= reg_rst;
    end else begin
      if (zac) begin
        cdi_q <= cdi;
      end
      if (rd_strobe) begin
        case (ca[7:0])
          sta_port:  rd_q <= sta;
          kbd_port:  rd_q <= kbd;
          tsta_port: rd_q <= {{(8-tsta_w){1'b0}}, rtc_time.tsta};
          tim0_port: rd_q <= rtc_time.tim0;
          tim1_port: rd_q <= {{(8-tim1_w){1'b0}}, rtc_time.tim1};
          tim2_port: rd_q <= rtc_time.timm[7:0];
          tim3_port: rd_q <= rtc_time.timm[15:8];
          tim4_port: rd_q <= {{(24-timm_w){1'b0}}, rtc_time.timm[timm_w-1:16]};
          default: ;  // Unmapped port keeps last value
        endcase
      end
    end
  end

  // Port data during IORQ, latched bus otherwise
  assign z80_cdo = !ctl.ior_n ? rd_q : cdi_q;

endmodule

`default_nettype wire

//--- keyboard_scan.sv
`default_nettype none

module keyboard_scan (
  input  logic               mck,
  input  logic               rst,
  input  logic [7:0]         ca_high,     // Row select, low selects
  input  logic [63:0]        kbmat,       // High for a pressed key
  input  blink_pkg::io_wr_t  io_wr,
  output logic [7:0]         kbd,
  output logic               kbd_status
);
  import blink_pkg::*;

  logic kbd_ack;

  // Pressed key pulls its bit low in every selected row
  always_comb begin
    kbd = 8'hFF;
    for (int i = 0; i < 8; i++) begin
      if (!ca_high[i]) begin
        kbd = kbd & ~kbmat[8*i +: 8];
      end
    end
  end

  assign kbd_ack = io_wr.strobe && (io_wr.port == ack_port) && io_wr.data[2];

  always_ff @(posedge mck) begin
    if (rst) begin
      kbd_status <= 1'b0;
    end else if (kbd != 8'hFF) begin
      kbd_status <= 1'b1;  // Held key keeps it set through ACK
    end else if (kbd_ack) begin
      kbd_status <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- mem_map.sv
`default_nettype none

module mem_map (
  input  logic                   mck,
  input  logic                   rst,
  input  logic [15:0]            ca,
  input  logic [21:0]            va,      // Video address outside zac
  input  blink_pkg::io_wr_t      io_wr,
  input  blink_pkg::z80_ctl_t    ctl,
  input  logic                   zac,
  output logic                   restim,  // COM bit 4
  output logic [21:0]            ma,
  output logic                   ipce_n,
  output logic                   irce_n,
  output logic                   wrb_n,
  output logic                   roe_n
);
  import blink_pkg::*;

  logic [seg_w-1:0]  sr [4];  // Segment registers
  logic [7:0]        com;
  logic [phys_w-1:0] za;      // Translated Z80 address
  logic              bank0;   // ma in banks 00-1F
  logic              bank1;   // ma in banks 20-3F

  always_ff @(posedge mck) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        sr[i] <= reg_rst;
      end
      com <= reg_rst;
    end else if (io_wr.strobe) begin
      case (io_wr.port)
        sr0_port: sr[0] <= io_wr.data;
        sr1_port: sr[1] <= io_wr.data;
        sr2_port: sr[2] <= io_wr.data;
        sr3_port: sr[3] <= io_wr.data;
        com_port: com   <= io_wr.data;
        default: ;
      endcase
    end
  end

  assign restim = com[4];

  always_comb begin
    case (ca[15:14])
      2'b11: za = {sr[3], ca[13:0]};  // C000-FFFF
      2'b10: za = {sr[2], ca[13:0]};  // 8000-BFFF
      2'b01: za = {sr[1], ca[13:0]};  // 4000-7FFF
      default: begin
        if (ca[13]) begin
          za = {sr[0], 1'b1, ca[12:0]};  // 2000-3FFF, upper half of bank
        end else begin
          // 0000-1FFF, ROM bank 00 or RAM bank 20 with RAMS
          za = {2'b00, com[2], 6'b000000, ca[12:0]};
        end
      end
    endcase
  end

  // Z80 owns the bus in zac only
  assign ma = zac ? za : va;

  assign bank0 = (ma[21:19] == 3'b000);
  assign bank1 = (ma[21:19] == 3'b001);

  // Video fetches enable unconditionally, CPU needs MREQ
  assign ipce_n = !(bank0 && (!zac || !ctl.mrq_n));
  assign irce_n = !(bank1 && (!zac || !ctl.mrq_n));

  assign wrb_n = !(zac && !ctl.mrq_n && ctl.crd_n);
  assign roe_n = zac ? !(!ctl.mrq_n && !ctl.crd_n) : 1'b0;  // Video reads outside zac

  a_we_oe_excl : assert property (@(posedge mck) disable iff (rst)
    !(!wrb_n && !roe_n))
    else $error("wrb_n and roe_n both low");

endmodule

`default_nettype wire

//--- rtc_timer.sv
`default_nettype none

module rtc_timer #(
  parameter int tick_div = 49152  // mck cycles per 5 ms
) (
  input  logic                  mck,
  input  logic                  rst,
  input  logic                  flp,
  input  logic                  restim,
  input  blink_pkg::io_wr_t     io_wr,
  output blink_pkg::rtc_time_t  rtc_time,
  output logic                  rtc_int
);
  import blink_pkg::*;

  localparam int tck_w = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [tck_w-1:0]  tck;       // Prescaler
  logic [tim0_w-1:0] tim0;
  logic [tim1_w-1:0] tim1;
  logic [timm_w-1:0] timm;
  logic [tsta_w-1:0] tsta;      // MIN, SEC, TICK
  logic [tsta_w-1:0] tmk;
  logic [tsta_w-1:0] tack_clr;
  logic              tick;
  logic              sec_wrap;
  logic              min_wrap;

  assign tick     = (tck == tck_w'(tick_div - 1));
  assign sec_wrap = tick && (tim0 == tim0_max);
  assign min_wrap = sec_wrap && (tim1 == tim1_max);

  // Counters survive a warm reset, hard reset needs the flap open
  always_ff @(posedge mck) begin
    if ((rst && flp) || restim) begin
      tck  <= '0;
      tim0 <= '0;
      tim1 <= '0;
      timm <= '0;
    end else begin
      tck <= tick ? '0 : tck + 1'b1;
      if (tick) begin
        tim0 <= sec_wrap ? '0 : tim0 + 1'b1;
      end
      if (sec_wrap) begin
        tim1 <= min_wrap ? '0 : tim1 + 1'b1;
      end
      if (min_wrap) begin
        timm <= timm + 1'b1;  // Free running minutes
      end
    end
  end

  // TACK clears only the bits written as one
  assign tack_clr = (io_wr.strobe && io_wr.port == tack_port) ?
                    io_wr.data[tsta_w-1:0] : '0;

  always_ff @(posedge mck) begin
    if (rst) begin
      tsta <= '0;
      tmk  <= '0;
    end else begin
      tsta <= (tsta & ~tack_clr) | {min_wrap, sec_wrap, tick};  // New event wins
      if (io_wr.strobe && io_wr.port == tmk_port) begin
        tmk <= io_wr.data[tsta_w-1:0];
      end
    end
  end

  assign rtc_int  = |(tsta & tmk);
  assign rtc_time = '{tim0: tim0, tim1: tim1, timm: timm, tsta: tsta};

  a_tim0_range : assert property (@(posedge mck) disable iff (rst)
    tim0 <= tim0_max)
    else $error("tim0 above wrap point");

  a_tim1_range : assert property (@(posedge mck) disable iff (rst)
    tim1 <= tim1_max)
    else $error("tim1 above wrap point");

endmodule

`default_nettype wire

//--- tb_blink.sv
`default_nettype none

module tb_blink;
  timeunit 1ns;
  timeprecision 100ps;
  import blink_pkg::*;

  localparam int tick_div   = 20;            // Short RTC tick for simulation
  localparam int irq_lim    = tick_div + 4;  // One tick plus flag and latch delay
  localparam int wake_lim   = 12;
  localparam int max_cycles = 6000;          // Several times the summed test length

  logic        mck;
  logic        rst;
  logic [15:0] ca;
  logic [21:0] va;
  logic [7:0]  cdi;
  logic [63:0] kbmat;
  logic        flp;
  logic        mrq_n;
  logic        crd_n;
  logic        ior_n;
  logic        cm1_n;
  logic        hlt_n;
  logic [21:0] ma;
  logic [7:0]  z80_cdo;
  logic [1:0]  clkcnt;
  logic        pm1;
  logic        ipce_n;
  logic        irce_n;
  logic        wrb_n;
  logic        roe_n;
  logic        intb_n;
  logic        nmib_n;

  logic [3:0][7:0] sr_m;  // Segment register model
  logic [7:0]      com_m;

  // Check enables set by the stimulus
  logic       map_chk;
  logic       rd_chk;
  logic       lvl_chk;
  logic       lvl_exp;
  logic       irq_go;
  logic       pm1_hold;
  logic       wake;
  logic [7:0] rd_mask;
  logic [7:0] rd_lo;
  logic [7:0] rd_hi;
  logic [7:0] rd_val;    // Last masked read
  logic [7:0] row_sel [4] = '{8'hF7, 8'hBF, 8'hB7, 8'hFE};

  integer seed    = 47;
  int     err_cnt = 0;
  int     test_no = 0;
  int     cyc     = 0;
  int     tck_ref;  // Prescaler phase since reset
  int     div_ref;  // Divider phase stepping 0 1 2

  blink_top #(.tick_div(tick_div)) DUT (
    .mck(mck), .rst(rst), .ca(ca), .va(va), .cdi(cdi), .kbmat(kbmat), .flp(flp),
    .mrq_n(mrq_n), .crd_n(crd_n), .ior_n(ior_n), .cm1_n(cm1_n), .hlt_n(hlt_n),
    .ma(ma), .z80_cdo(z80_cdo), .clkcnt(clkcnt), .pm1(pm1), .ipce_n(ipce_n),
    .irce_n(irce_n), .wrb_n(wrb_n), .roe_n(roe_n), .intb_n(intb_n), .nmib_n(nmib_n)
  );

  initial begin
    mck = 1'b0;
    forever #2 mck = ~mck;
  end

  // Tick happens on the edge after phase tick_div-1
  always @(posedge mck) begin
    if (rst) tck_ref <= 0;
    else tck_ref <= (tck_ref == tick_div - 1) ? 0 : tck_ref + 1;
  end

  // One access cycle in every three mck cycles
  always @(posedge mck) begin
    if (rst) div_ref <= 0;
    else div_ref <= (div_ref + 1) % 3;
  end

  // Expected physical address for a Z80 address
  function automatic logic [21:0] map_ref(input logic [15:0] a, input logic [3:0][7:0] sr,
                                          input logic [7:0] com);
    logic [7:0] bank;
    if (a[15:14] != 2'd0) bank = sr[a[15:14]];
    else if (a[13]) bank = sr[0];               // Upper half of SR0 bank
    else bank = com[2] ? 8'h20 : 8'h00;         // RAMS picks RAM bank
    return {bank, a[13:0]};
  endfunction

  // Expected {ipce_n, irce_n} for a physical address
  function automatic logic [1:0] ce_ref(input logic [21:0] pa);
    return {pa[21:19] != 3'd0, pa[21:19] != 3'd1};
  endfunction

  // Column j reads low when any selected row has key j down
  function automatic logic [7:0] kbd_ref(input logic [7:0] hi, input logic [63:0] mat);
    logic [7:0] v;
    v = 8'hFF;
    for (int j = 0; j < 8; j++) begin
      for (int r = 0; r < 8; r++) begin
        if (!hi[r] && mat[8*r+j]) v[j] = 1'b0;
      end
    end
    return v;
  endfunction

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic sync_clk(input logic [1:0] phase);
    do begin
      @(posedge mck);
      #1;
    end while (clkcnt != phase);
  endtask

  task automatic io_write(input logic [7:0] port, input logic [7:0] hi, input logic [7:0] data);
    sync_clk(2'd2);  // Inside the access cycle
    ca    = {hi, port};
    cdi   = data;
    ior_n = 1'b0;
    crd_n = 1'b1;
    @(posedge mck);
    #1;
    ior_n = 1'b1;
    ca    = 16'h0000;
    if (port >= sr0_port && port <= sr3_port) sr_m[port[1:0]] = data;
    else if (port == com_port) com_m = data;
  endtask

  task automatic io_read(input logic [7:0] port, input logic [7:0] hi, input logic [7:0] mask,
                         input logic [7:0] lo, input logic [7:0] top);
    sync_clk(2'd2);
    ca    = {hi, port};
    ior_n = 1'b0;
    crd_n = 1'b0;
    @(posedge mck);  // Read register loads here
    #1;
    rd_mask = mask;
    rd_lo   = lo;
    rd_hi   = top;
    rd_chk  = 1'b1;
    @(posedge mck);
    #1;
    rd_val = z80_cdo & mask;
    rd_chk = 1'b0;
    ior_n  = 1'b1;
    crd_n  = 1'b1;
    ca     = 16'h0000;
  endtask

  task automatic mem_cycle(input logic [15:0] addr, input logic wr);
    ca    = addr;
    mrq_n = 1'b0;
    crd_n = wr;  // RD stays high for a write
    repeat (3) @(posedge mck);  // Spans one full divider round
    #1;
    mrq_n = 1'b1;
    crd_n = 1'b1;
  endtask

  // Z80 interrupt acknowledge kept outside zac
  task automatic ack_cycle;
    sync_clk(2'd0);
    ior_n = 1'b0;
    cm1_n = 1'b0;
    repeat (2) @(posedge mck);
    #1;
    ior_n = 1'b1;
    cm1_n = 1'b1;
  endtask

  task automatic check_int_level(input logic exp);
    lvl_exp = exp;
    lvl_chk = 1'b1;
    @(posedge mck);
    #1;
    lvl_chk = 1'b0;
  endtask

  task automatic wait_tick_phase(input int phase);
    do begin
      @(posedge mck);
      #1;
    end while (tck_ref != phase);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_no++;
    if (err_cnt == errs_before) $display("Test %0d %s: ok", test_no, name);
    else $display("Test %0d %s: %0d errors", test_no, name, err_cnt - errs_before);
  endtask

  a_div : assert property (@(posedge mck) disable iff (rst)
    clkcnt == 2'(div_ref))
    else flag_error($sformatf("clkcnt %0d where phase %0d expected", clkcnt, div_ref));

  a_map_ma : assert property (@(posedge mck) disable iff (rst)
    (map_chk && clkcnt == 2'd2) |-> ma == map_ref(ca, sr_m, com_m))
    else flag_error($sformatf("ma 0x%06h for ca 0x%04h", ma, ca));

  a_map_va : assert property (@(posedge mck) disable iff (rst)
    (map_chk && clkcnt != 2'd2) |-> ma == va)
    else flag_error("ma does not carry va outside the access cycle");

  a_map_ce : assert property (@(posedge mck) disable iff (rst)
    (map_chk && clkcnt == 2'd2 && !mrq_n) |->
      {ipce_n, irce_n} == ce_ref(map_ref(ca, sr_m, com_m)))
    else flag_error($sformatf("chip enables %b%b for ma 0x%06h", ipce_n, irce_n, ma));

  // Video keeps the memory output enabled outside the access cycle
  a_mem_ctl : assert property (@(posedge mck) disable iff (rst)
    map_chk |-> {wrb_n, roe_n} ==
      ((clkcnt == 2'd2) ? {mrq_n || !crd_n, mrq_n || crd_n} : 2'b10))
    else flag_error($sformatf("wrb_n %b roe_n %b", wrb_n, roe_n));

  a_rd_val : assert property (@(posedge mck) disable iff (rst)
    rd_chk |-> ((z80_cdo & rd_mask) >= rd_lo) && ((z80_cdo & rd_mask) <= rd_hi))
    else flag_error($sformatf("read 0x%02h outside 0x%02h..0x%02h",
                              z80_cdo & rd_mask, rd_lo, rd_hi));

  a_int_lvl : assert property (@(posedge mck) disable iff (rst)
    lvl_chk |-> intb_n == lvl_exp)
    else flag_error($sformatf("intb_n is %b", intb_n));

  a_irq : assert property (@(posedge mck) disable iff (rst)
    $rose(irq_go) |-> ##[0:irq_lim] !intb_n)
    else flag_error("intb_n did not fall in time");

  a_snooze : assert property (@(posedge mck) disable iff (rst)
    pm1_hold |-> !pm1)
    else flag_error("pm1 ran during snooze");

  a_wake : assert property (@(posedge mck) disable iff (rst)
    $rose(wake) |-> ##[1:wake_lim] pm1)
    else flag_error("pm1 did not resume after keyboard interrupt");

  a_nmi : assert property (@(posedge mck) disable iff (rst)
    nmib_n == !flp)
    else flag_error($sformatf("nmib_n %b with flp %b", nmib_n, flp));

  initial begin
    int         e0;
    logic [7:0] v;
    ca    = '0;
    va    = '0;
    cdi   = '0;
    kbmat = '0;
    flp   = 1'b1;  // Flap open so reset clears the RTC
    mrq_n = 1'b1;
    crd_n = 1'b1;
    ior_n = 1'b1;
    cm1_n = 1'b1;
    hlt_n = 1'b1;
    rst   = 1'b1;
    map_chk  = 1'b0;
    rd_chk   = 1'b0;
    lvl_chk  = 1'b0;
    lvl_exp  = 1'b1;
    irq_go   = 1'b0;
    pm1_hold = 1'b0;
    wake     = 1'b0;
    rd_mask  = '0;
    rd_lo    = '0;
    rd_hi    = '0;
    rd_val   = '0;
    sr_m  = '0;
    com_m = '0;
    repeat (10) @(posedge mck);
    #1;
    rst = 1'b0;
    flp = 1'b0;

    e0 = err_cnt;
    va = 22'($random(seed));
    map_chk = 1'b1;
    for (int s = 0; s < 4; s++) io_write(sr0_port + 8'(s), 8'h00, 8'($random(seed)));
    for (int r = 0; r < 8; r++) mem_cycle({3'(r), 13'($random(seed))}, r[0]);  // Odd ones write
    report_test("bank mapping", e0);

    e0 = err_cnt;
    for (int k = 0; k < 4; k++) begin
      io_write(com_port, 8'h00, k[0] ? 8'h00 : 8'h04);  // RAMS on then off
      mem_cycle({3'b000, 13'($random(seed))}, 1'b0);
      mem_cycle(16'h1FFF, 1'b1);
    end
    map_chk = 1'b0;
    report_test("RAMS", e0);

    e0 = err_cnt;
    io_read(tim0_port, 8'h00, 8'hFF, 8'h00, tim0_max);
    v = rd_val;
    repeat (tick_div + 3) @(posedge mck);
    #1;
    io_read(tim0_port, 8'h00, 8'hFF, v + 8'd1, tim0_max);  // At least one tick later
    io_write(tack_port, 8'h00, 8'h07);
    io_write(tmk_port, 8'h00, 8'h01);
    io_write(int_port, 8'h00, 8'h03);  // GINT and TIME
    irq_go = 1'b1;
    repeat (irq_lim + 2) @(posedge mck);
    #1;
    irq_go = 1'b0;
    wait_tick_phase(2);  // Far from the next tick
    io_write(tack_port, 8'h00, 8'h07);
    ack_cycle;
    check_int_level(1'b1);
    io_write(com_port, 8'h00, 8'h10);  // RESTIM pulse
    io_write(com_port, 8'h00, 8'h00);
    io_read(tim0_port, 8'h00, 8'hFF, 8'h00, 8'h01);
    report_test("RTC", e0);

    e0 = err_cnt;
    io_write(int_port, 8'h00, 8'h00);
    io_write(tmk_port, 8'h00, 8'h00);
    ack_cycle;
    check_int_level(1'b1);
    kbmat[8*3+5] = 1'b1;
    kbmat[8*6+1] = 1'b1;
    kbmat[8*6+7] = 1'b1;
    for (int i = 0; i < 4; i++) begin
      io_read(kbd_port, row_sel[i], 8'hFF, kbd_ref(row_sel[i], kbmat),
              kbd_ref(row_sel[i], kbmat));
    end
    io_write(int_port, 8'h00, 8'h05);  // GINT and KEY
    irq_go = 1'b1;
    repeat (irq_lim + 2) @(posedge mck);
    #1;
    irq_go = 1'b0;
    report_test("keyboard", e0);

    e0 = err_cnt;
    kbmat = '0;
    io_write(ack_port, 8'h00, 8'h04);
    ack_cycle;
    check_int_level(1'b1);
    io_write(int_port, 8'h00, 8'h85);  // KWAIT with KEY and GINT
    io_read(kbd_port, 8'hFF, 8'hFF, 8'hFF, 8'hFF);
    pm1_hold = 1'b1;
    repeat (12) @(posedge mck);
    #1;
    pm1_hold = 1'b0;
    kbmat[8*2+4] = 1'b1;  // Key press wakes the clock
    wake = 1'b1;
    repeat (wake_lim + 2) @(posedge mck);
    #1;
    wake = 1'b0;
    report_test("snooze", e0);

    e0 = err_cnt;
    kbmat = '0;
    io_write(ack_port, 8'h00, 8'h04);
    ack_cycle;
    check_int_level(1'b1);
    flp = 1'b1;
    repeat (2) @(posedge mck);
    #1;
    io_read(sta_port, 8'h00, 8'hFF, 8'hA0, 8'hA0);  // FLAPOPEN and FLAP
    flp = 1'b0;
    io_write(ack_port, 8'h00, 8'h20);
    io_read(sta_port, 8'h00, 8'hFF, 8'h00, 8'h00);
    report_test("flap", e0);

    repeat (4) @(posedge mck);
    $display("Summary: %0d tests, %0d errors", test_no, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    while (cyc < max_cycles) begin
      @(posedge mck);
      cyc++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", max_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- z80_clock_gen.sv
`default_nettype none

module z80_clock_gen (
  input  logic       mck,
  input  logic       rst,
  input  logic       int_active,  // INT latch set
  input  logic       hlt_n,
  input  logic       snooze_req,  // KWAIT keyboard read
  output logic       zac,
  output logic [1:0] clkcnt,
  output logic       pm1
);
  import blink_pkg::*;

  logic run;    // Clock enable, cleared by HALT or snooze
  logic pulse;  // Cycle after the access cycle

  assign zac = (clkcnt == 2'd2);  // Access cycle

  always_ff @(posedge mck) begin
    if (rst) begin
      clkcnt <= 2'd0;
      pulse  <= 1'b0;
      run    <= run_rst;
    end else begin
      clkcnt <= zac ? 2'd0 : clkcnt + 2'd1;  // Divide by three
      pulse  <= zac;
      // Wake beats sleep in the same cycle
      if (int_active) begin
        run <= 1'b1;
      end else if (!hlt_n || snooze_req) begin
        run <= 1'b0;
      end
    end
  end

  // Gated Z80 clock
  assign pm1 = pulse & run;

  a_clkcnt_range : assert property (@(posedge mck) disable iff (rst)
    clkcnt != 2'd3)
    else $error("clock divider count reached 3");

endmodule

`default_nettype wire
